//--- hw/fetch_pkg.sv
package fetch_pkg;

    // basic widths
    localparam int ADDR_W = 32;
    localparam int INSTR_W = 32;

    // two instructions per fetch
    localparam int SLOTS = 2;
    localparam int PAIR_W = SLOTS * INSTR_W;

    // bytes advanced per sequential fetch
    localparam int FETCH_STRIDE = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [INSTR_W-1:0] instr_t;

    // lower half at pc, upper half at pc + 4
    typedef logic [PAIR_W-1:0] pair_t;

    // boot address, kseg1 uncached
    localparam addr_t RESET_VECTOR = 32'hbfc0_0000;

    // rising priority, compared by value
    typedef enum logic [1:0] {
        REDIR_NONE   = 2'd0,
        REDIR_BRANCH = 2'd1,
        REDIR_ERET   = 2'd2,
        REDIR_EXC    = 2'd3
    } redirect_kind_t;

endpackage

//--- hw/redirect_if.sv
interface redirect_if;

    // resolved branch from execute
    logic             branch_taken;
    fetch_pkg::addr_t branch_target;

    // exception return
    logic             eret;
    fetch_pkg::addr_t epc;

    // exception entry
    logic             exc;
    fetch_pkg::addr_t entrance;

    modport sink (
        input branch_taken,
        input branch_target,
        input eret,
        input epc,
        input exc,
        input entrance
    );

endinterface

//--- hw/fetch_if.sv
interface fetch_if;

    // pc of the request stage
    fetch_pkg::addr_t pc;

    // request accepted by the bus this cycle
    logic req_fire;
    logic misaligned;

    // redirect taken, flush downstream
    logic kill;

    modport source (
        output pc,
        output req_fire,
        output misaligned,
        output kill
    );

    modport sink (
        input pc,
        input req_fire,
        input misaligned,
        input kill
    );

endinterface

//--- hw/pc_select.sv
module pc_select #(
    parameter fetch_pkg::addr_t P_RESET_VECTOR = fetch_pkg::RESET_VECTOR
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             i_stall_d,
    input  logic             i_addr_ok,
    redirect_if.sink         redir,
    fetch_if.source          fetch,
    output logic             o_ireq_valid,
    output fetch_pkg::addr_t o_ireq_addr
);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t pc_nxt;
    fetch_pkg::addr_t new_target;
    fetch_pkg::addr_t saved_target;
    fetch_pkg::addr_t redir_target;

    fetch_pkg::redirect_kind_t new_kind;
    fetch_pkg::redirect_kind_t saved_kind;
    fetch_pkg::redirect_kind_t redir_kind;

    logic misaligned;
    logic take_new;
    logic redirect_taken;
    logic advance;

    assign misaligned = |pc_q[1:0];

    // no bus request for a misaligned pc
    assign o_ireq_valid = ~misaligned & ~reset;
    assign o_ireq_addr = pc_q;

    // fixed priority among this cycle's strobes
    always_comb begin
        new_kind = fetch_pkg::REDIR_NONE;
        new_target = redir.branch_target;
        if (redir.exc) begin
            new_kind = fetch_pkg::REDIR_EXC;
            new_target = redir.entrance;
        end else if (redir.eret) begin
            new_kind = fetch_pkg::REDIR_ERET;
            new_target = redir.epc;
        end else if (redir.branch_taken) begin
            new_kind = fetch_pkg::REDIR_BRANCH;
            new_target = redir.branch_target;
        end
    end

    // a saved redirect only yields to an equal or stronger one
    assign take_new = (new_kind != fetch_pkg::REDIR_NONE) && (new_kind >= saved_kind);
    assign redir_kind = take_new ? new_kind : saved_kind;
    assign redir_target = take_new ? new_target : saved_target;

    assign redirect_taken = ~i_stall_d && (redir_kind != fetch_pkg::REDIR_NONE);

    // misaligned pc moves on without the bus, it becomes an exception slot
    assign advance = ~i_stall_d & ((o_ireq_valid & i_addr_ok) | misaligned);

    always_comb begin
        pc_nxt = pc_q;
        if (redirect_taken) begin
            pc_nxt = redir_target;
        end else if (advance) begin
            pc_nxt = pc_q + fetch_pkg::addr_t'(fetch_pkg::FETCH_STRIDE);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= P_RESET_VECTOR;
        end else if (~i_stall_d) begin
            pc_q <= pc_nxt;
        end
    end

    // redirect seen during a stall waits here
    always_ff @(posedge clk) begin
        if (reset) begin
            saved_kind <= fetch_pkg::REDIR_NONE;
        end else if (~i_stall_d) begin
            saved_kind <= fetch_pkg::REDIR_NONE;
        end else if (take_new) begin
            saved_kind <= new_kind;
        end
    end

    always_ff @(posedge clk) begin
        if (i_stall_d && take_new) begin
            saved_target <= new_target;
        end
    end

    assign fetch.pc = pc_q;
    assign fetch.req_fire = ~i_stall_d & o_ireq_valid & i_addr_ok;
    assign fetch.misaligned = misaligned;
    assign fetch.kill = redirect_taken;

endmodule

//--- hw/fetch_stage.sv
module fetch_stage (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       i_stall_d,
    fetch_if.sink                                      fetch,
    input  fetch_pkg::pair_t                           i_iresp_data,
    output logic [fetch_pkg::SLOTS-1:0]                o_slot_valid,
    output fetch_pkg::addr_t [fetch_pkg::SLOTS-1:0]    o_slot_pc,
    output fetch_pkg::instr_t [fetch_pkg::SLOTS-1:0]   o_slot_instr,
    output logic [fetch_pkg::SLOTS-1:0]                o_slot_exc
);

    // fetch register
    logic             f_valid;
    logic             f_misaligned;
    fetch_pkg::addr_t f_pc;

    // response captured during a stall
    logic             hold_valid;
    fetch_pkg::pair_t hold_data;
    fetch_pkg::pair_t resp;

    logic [fetch_pkg::SLOTS-1:0]              nxt_valid;
    logic [fetch_pkg::SLOTS-1:0]              nxt_exc;
    fetch_pkg::addr_t [fetch_pkg::SLOTS-1:0]  nxt_pc;
    fetch_pkg::instr_t [fetch_pkg::SLOTS-1:0] nxt_instr;

    always_ff @(posedge clk) begin
        if (reset) begin
            f_valid <= 1'b0;
        end else if (~i_stall_d) begin
            f_valid <= ~fetch.kill & (fetch.req_fire | fetch.misaligned);
        end
    end

    always_ff @(posedge clk) begin
        if (~i_stall_d) begin
            f_pc <= fetch.pc;
            f_misaligned <= fetch.misaligned;
        end
    end

    // first stalled cycle carries the data of f_pc, keep only that one
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (i_stall_d && ~hold_valid) begin
            hold_valid <= 1'b1;
        end else if (~i_stall_d) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_stall_d && ~hold_valid) begin
            hold_data <= i_iresp_data;
        end
    end

    assign resp = hold_valid ? hold_data : i_iresp_data;

    // slot 1 at pc, slot 0 at pc + 4
    always_comb begin
        nxt_valid[1] = f_valid;
        nxt_pc[1] = f_pc;
        nxt_instr[1] = resp[fetch_pkg::INSTR_W-1:0];
        nxt_exc[1] = f_valid & f_misaligned;

        nxt_valid[0] = f_valid & ~f_misaligned;
        nxt_pc[0] = f_pc + 32'd4;
        nxt_instr[0] = resp[fetch_pkg::PAIR_W-1:fetch_pkg::INSTR_W];
        nxt_exc[0] = 1'b0;

        if (f_misaligned) begin
            nxt_instr[1] = '0;
            nxt_instr[0] = '0;
        end
    end

    // output register toward decode
    always_ff @(posedge clk) begin
        if (reset || fetch.kill) begin
            o_slot_valid <= '0;
            o_slot_exc <= '0;
        end else if (~i_stall_d) begin
            o_slot_valid <= nxt_valid;
            o_slot_exc <= nxt_exc;
        end
    end

    always_ff @(posedge clk) begin
        if (~i_stall_d) begin
            o_slot_pc <= nxt_pc;
            o_slot_instr <= nxt_instr;
        end
    end

endmodule

//--- hw/fetch_front.sv
module fetch_front #(
    parameter fetch_pkg::addr_t P_RESET_VECTOR = fetch_pkg::RESET_VECTOR
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       i_stall_d,

    // redirects from the back end
    input  logic                                       i_branch_taken,
    input  fetch_pkg::addr_t                           i_branch_target,
    input  logic                                       i_eret,
    input  fetch_pkg::addr_t                           i_epc,
    input  logic                                       i_exc,
    input  fetch_pkg::addr_t                           i_entrance,

    // instruction bus
    output logic                                       o_ireq_valid,
    output fetch_pkg::addr_t                           o_ireq_addr,
    input  logic                                       i_iresp_addr_ok,
    input  fetch_pkg::pair_t                           i_iresp_data,

    // toward decode
    output logic [fetch_pkg::SLOTS-1:0]                o_slot_valid,
    output fetch_pkg::addr_t [fetch_pkg::SLOTS-1:0]    o_slot_pc,
    output fetch_pkg::instr_t [fetch_pkg::SLOTS-1:0]   o_slot_instr,
    output logic [fetch_pkg::SLOTS-1:0]                o_slot_exc
);

    redirect_if u_redir ();
    fetch_if u_fetch ();

    assign u_redir.branch_taken = i_branch_taken;
    assign u_redir.branch_target = i_branch_target;
    assign u_redir.eret = i_eret;
    assign u_redir.epc = i_epc;
    assign u_redir.exc = i_exc;
    assign u_redir.entrance = i_entrance;

    pc_select #(
        .P_RESET_VECTOR(P_RESET_VECTOR)
    ) u_pc_select (
        .clk          (clk),
        .reset        (reset),
        .i_stall_d    (i_stall_d),
        .i_addr_ok    (i_iresp_addr_ok),
        .redir        (u_redir.sink),
        .fetch        (u_fetch.source),
        .o_ireq_valid (o_ireq_valid),
        .o_ireq_addr  (o_ireq_addr)
    );

    fetch_stage u_fetch_stage (
        .clk          (clk),
        .reset        (reset),
        .i_stall_d    (i_stall_d),
        .fetch        (u_fetch.sink),
        .i_iresp_data (i_iresp_data),
        .o_slot_valid (o_slot_valid),
        .o_slot_pc    (o_slot_pc),
        .o_slot_instr (o_slot_instr),
        .o_slot_exc   (o_slot_exc)
    );

endmodule

//--- dv/fetch_front_assertions.sv
module fetch_front_assertions (
    input logic                                     clk,
    input logic                                     reset,
    input logic                                     i_stall_d,
    input logic                                     o_ireq_valid,
    input fetch_pkg::addr_t                         o_ireq_addr,
    input logic [fetch_pkg::SLOTS-1:0]              o_slot_valid,
    input fetch_pkg::addr_t [fetch_pkg::SLOTS-1:0]  o_slot_pc,
    input fetch_pkg::instr_t [fetch_pkg::SLOTS-1:0] o_slot_instr,
    input logic [fetch_pkg::SLOTS-1:0]              o_slot_exc
);

    int failures = 0;

    // the bus never sees a misaligned address
    a_req_aligned: assert property (@(posedge clk) disable iff (reset)
        o_ireq_valid |-> o_ireq_addr[1:0] == 2'b00)
        else begin
            $error("request raised for misaligned address %h", o_ireq_addr);
            failures++;
        end

    // decode sees frozen slots while stalled
    a_slots_hold: assert property (@(posedge clk) disable iff (reset)
        i_stall_d |=> $stable(o_slot_valid) && $stable(o_slot_pc)
                      && $stable(o_slot_instr) && $stable(o_slot_exc))
        else begin
            $error("slot outputs changed under stall");
            failures++;
        end

    a_exc_with_valid: assert property (@(posedge clk) disable iff (reset)
        (o_slot_exc & ~o_slot_valid) == '0)
        else begin
            $error("exception flag on an invalid slot");
            failures++;
        end

endmodule

//--- dv/tb_fetch_front.sv
module tb_fetch_front;

    localparam int TAIL_CYCLES = 40;
    localparam int DRAIN_CYCLES = 4;

    logic clk, reset, i_stall_d, i_iresp_addr_ok;
    logic i_branch_taken, i_eret, i_exc, o_ireq_valid;
    fetch_pkg::addr_t i_branch_target, i_epc, i_entrance, o_ireq_addr;
    fetch_pkg::pair_t i_iresp_data;
    logic [1:0] o_slot_valid, o_slot_exc;
    fetch_pkg::addr_t [1:0] o_slot_pc;
    fetch_pkg::instr_t [1:0] o_slot_instr;

    // reference model with kinds ranked 0 none, 1 branch, 2 eret, 3 exception
    fetch_pkg::addr_t m_pc, m_f_pc, m_saved_target, bus_addr;
    fetch_pkg::addr_t exp_q[$];
    int m_saved_kind;
    bit m_f_valid, bus_acc, last_stall;

    string case_line[$];
    string cur_name;
    logic [31:0] rng = 32'd74;
    int errors = 0;
    int cycles = 0;
    int cycle_limit = 100000;

    fetch_front DUT (.*);
    bind fetch_front fetch_front_assertions u_assertions (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles", cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_value(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s %s: expected %h, actual %h", cur_name, field, exp, act);
            errors++;
        end
    endtask

    // slots loaded at the last edge against the oldest expected fetch
    task automatic check_outputs();
        fetch_pkg::addr_t pc;
        if (!last_stall && exp_q.size() == 0) begin
            check_value("valid", 32'd0, o_slot_valid);
        end else if (!last_stall) begin
            pc = exp_q.pop_front();
            check_value("slot1 pc", pc, o_slot_pc[1]);
            if (pc[1:0] == 2'b00) begin
                check_value("valid", 32'd3, o_slot_valid);
                check_value("exc", 32'd0, o_slot_exc);
                check_value("slot1 instr", ~pc, o_slot_instr[1]);
                check_value("slot0 pc", pc + 32'd4, o_slot_pc[0]);
                check_value("slot0 instr", ~(pc + 32'd4), o_slot_instr[0]);
            end else begin
                check_value("valid", 32'd2, o_slot_valid);
                check_value("exc", 32'd2, o_slot_exc);
                check_value("slot1 instr", 32'd0, o_slot_instr[1]);
            end
        end
    endtask

    task automatic run_cycle(input string name, input bit stall, input bit ok,
                             input logic [2:0] strobes, input fetch_pkg::addr_t target);
        int kind;
        fetch_pkg::addr_t dest;
        check_outputs();
        check_value("request addr", m_pc, o_ireq_addr);
        check_value("request valid", 32'(m_pc[1:0] == 2'b00), 32'(o_ireq_valid));
        // memory answers one cycle after acceptance with each word its address inverted
        if (bus_acc) begin
            i_iresp_data = {~(bus_addr + 32'd4), ~bus_addr};
        end else begin
            i_iresp_data = {next_random(), next_random()};
        end
        i_stall_d = stall;
        i_iresp_addr_ok = ok;
        {i_exc, i_eret, i_branch_taken} = strobes;
        i_branch_target = target;
        i_epc = target + 32'h100;
        i_entrance = target + 32'h200;
        bus_acc = o_ireq_valid & ok;
        bus_addr = o_ireq_addr;
        last_stall = stall;
        cur_name = name;
        @(posedge clk);
        // strongest strobe, then ranked against a saved redirect
        kind = strobes[2] ? 3 : strobes[1] ? 2 : strobes[0] ? 1 : 0;
        dest = strobes[2] ? target + 32'h200 : strobes[1] ? target + 32'h100 : target;
        if (kind == 0 || kind < m_saved_kind) begin
            kind = m_saved_kind;
            dest = m_saved_target;
        end
        if (stall) begin
            m_saved_kind = kind;
            m_saved_target = dest;
        end else if (kind != 0) begin
            // both stages flushed
            m_f_valid = 1'b0;
            m_pc = dest;
            m_saved_kind = 0;
        end else begin
            if (m_f_valid) begin
                exp_q.push_back(m_f_pc);
            end
            m_f_valid = (m_pc[1:0] != 2'b00) | ok;
            m_f_pc = m_pc;
            if (m_f_valid) begin
                m_pc = m_pc + 32'd8;
            end
        end
        @(negedge clk);
    endtask

    initial begin
        int fd;
        int n;
        int stall;
        int ok;
        int strobes;
        string line;
        string name;
        logic [31:0] target;
        logic [31:0] rnd;
        reset = 1'b1;
        {i_stall_d, i_iresp_addr_ok, i_branch_taken, i_eret, i_exc} = '0;
        {i_branch_target, i_epc, i_entrance} = '0;
        i_iresp_data = '0;
        m_pc = 32'hbfc0_0000;
        m_f_pc = '0;
        m_saved_target = '0;
        m_saved_kind = 0;
        {m_f_valid, bus_acc, last_stall} = '0;
        cur_name = "reset";
        fd = $fopen("dv/fetch_cases.txt", "r");
        assert (fd != 0) else begin
            $display("ERROR: cannot open dv/fetch_cases.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                case_line.push_back(line);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        cycle_limit = 2 * (8 + case_line.size() + TAIL_CYCLES + DRAIN_CYCLES) + 50;

        repeat (8) @(negedge clk);
        assert (!o_ireq_valid && o_slot_valid == 2'b00 && o_slot_exc == 2'b00) else begin
            $display("ERROR: request or slots active during reset");
            errors++;
        end
        reset = 1'b0;
        @(negedge clk);
        cur_name = "boot";
        check_value("first request", 32'hbfc0_0000, o_ireq_addr);

        foreach (case_line[i]) begin
            n = $sscanf(case_line[i], "%s %d %d %h %h", name, stall, ok, strobes, target);
            assert (n == 5) else begin
                $display("ERROR: case line %0d cannot be parsed", i);
                errors++;
            end
            if (n == 5) begin
                run_cycle(name, stall[0], ok[0], strobes[2:0], target);
            end
        end
        // random stalls and bus refusals without redirects
        for (int i = 0; i < TAIL_CYCLES; i++) begin
            rnd = next_random();
            run_cycle("random_tail", rnd[0] & rnd[1], |rnd[3:2], 3'b000, '0);
        end
        repeat (DRAIN_CYCLES) run_cycle("drain", 1'b0, 1'b0, 3'b000, '0);
        check_outputs();

        $display("cases: %0d, errors: %0d, assertion failures: %0d",
                 case_line.size(), errors, DUT.u_assertions.failures);
        if (errors == 0 && DUT.u_assertions.failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- fetch_front.f
hw/fetch_pkg.sv
hw/redirect_if.sv
hw/fetch_if.sv
hw/pc_select.sv
hw/fetch_stage.sv
hw/fetch_front.sv
dv/fetch_front_assertions.sv
dv/tb_fetch_front.sv

//--- dv/fetch_cases.txt
# name stall addr_ok strobes(hex: 1 branch, 2 eret, 4 exception) target(hex)
# eret returns to target+100, exception entrance is target+200
boot 0 1 0 00000000
boot 0 1 0 00000000
boot 0 0 0 00000000
boot 0 1 0 00000000
priority_all 0 1 7 00001000
priority_all 0 1 0 00000000
priority_eret 0 1 3 00002000
priority_eret 0 1 0 00000000
priority_branch 0 1 1 00003000
stall_redirect 1 1 1 00004000
stall_redirect 1 1 2 00005000
stall_redirect 1 1 1 00006000
stall_redirect 0 1 0 00000000
stall_redirect 0 1 0 00000000
stall_hold 0 1 0 00000000
stall_hold 1 1 0 00000000
stall_hold 1 0 0 00000000
stall_hold 0 1 0 00000000
misaligned 0 1 1 00007002
misaligned 0 1 0 00000000
misaligned 0 1 0 00000000
misaligned_exc 0 1 4 00008000
misaligned_exc 0 1 0 00000000
